//--- Makefile
TOP       ?= tb_bnn_classifier
SEED      ?= 89
LOG       ?= sim.log
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP SEED LOG FILELIST BUILD_DIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gseed=$(SEED) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bnn_argmax.sv
`timescale 1ns/1ps

module bnn_argmax (
  input logic [bnn_pkg::num_classes-1:0][bnn_pkg::score_bits-1:0] scores,
  output logic [bnn_pkg::class_bits-1:0] klass
);
  import bnn_pkg::*;

  logic [score_bits-1:0] best_score;

  // Strict compare keeps the lower index on a tie
  always_comb begin
    best_score = scores[0];
    klass = '0;
    for (int k = 1; k < num_classes; k++) begin
      if (scores[k] > best_score) begin
        best_score = scores[k];
        klass = class_bits'(k);
      end
    end
  end

endmodule

//--- bnn_classifier.sv
`timescale 1ns/1ps

module bnn_classifier (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic [bnn_pkg::wb_addr_bits-1:0] wb_adr,
  input logic [bnn_pkg::wb_data_bits-1:0] wb_dat_w,
  output logic [bnn_pkg::wb_data_bits-1:0] wb_dat_r,
  output logic wb_ack
);
  import bnn_pkg::*;

  logic [num_hidden-1:0] hidden_bits;
  logic hidden_valid;

  bnn_ctrl_if ctrl_bus ();

  bnn_wb_regs regs0 (
    .clk(clk),
    .rst(rst),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack),
    .ctrl(ctrl_bus.regs)
  );

  bnn_hidden_layer hidden0 (
    .clk(clk),
    .rst(rst),
    .start(ctrl_bus.start),
    .features(ctrl_bus.features),
    .hidden_bits(hidden_bits),
    .hidden_valid(hidden_valid)
  );

  bnn_output_layer output0 (
    .clk(clk),
    .rst(rst),
    .hidden_bits(hidden_bits),
    .hidden_valid(hidden_valid),
    .ctrl(ctrl_bus.net)
  );

  bnn_argmax argmax0 (
    .scores(ctrl_bus.scores),
    .klass(ctrl_bus.klass)
  );

endmodule

//--- bnn_ctrl_if.sv
`timescale 1ns/1ps

interface bnn_ctrl_if;
  import bnn_pkg::*;

  logic start;
  logic [num_features-1:0][feature_bits-1:0] features;
  logic done;
  logic [num_classes-1:0][score_bits-1:0] scores;
  logic [class_bits-1:0] klass;

  modport regs (
    output start,
    output features,
    input done,
    input scores,
    input klass
  );

  modport net (
    input start,
    input features,
    output done,
    output scores,
    output klass
  );

endinterface

//--- bnn_hidden_layer.sv
`timescale 1ns/1ps

module bnn_hidden_layer (
  input logic clk,
  input logic rst,
  input logic start,
  input logic [bnn_pkg::num_features-1:0][bnn_pkg::feature_bits-1:0] features,
  output logic [bnn_pkg::num_hidden-1:0] hidden_bits,
  output logic hidden_valid
);
  import bnn_pkg::*;

  logic running;
  logic last;
  logic [feat_cnt_bits-1:0] cnt;
  logic [num_features-1:0][feature_bits-1:0] feat_q;
  logic [feature_bits-1:0] cur_feat;
  logic signed [acc_bits-1:0] feat_ext;
  logic [num_hidden-1:0] row;

  assign last = running && (cnt == feat_cnt_bits'(num_features - 1));
  assign hidden_valid = last;  // Final sums are the next_acc values of this cycle

  assign cur_feat = feat_q[cnt];
  assign feat_ext = signed'({{(acc_bits - feature_bits){1'b0}}, cur_feat});
  assign row = hidden_weights[cnt];

  // Snapshot so bus writes during a run do not disturb it
  always_ff @(posedge clk) begin
    if (start) begin
      feat_q <= features;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
      running <= 1'b0;
    end else if (start) begin
      cnt <= '0;
      running <= 1'b1;
    end else if (running) begin
      if (last) begin
        cnt <= '0;
        running <= 1'b0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  for (genvar i = 0; i < num_hidden; i++) begin : g_neuron
    logic signed [acc_bits-1:0] acc;
    logic signed [acc_bits-1:0] next_acc;

    assign next_acc = row[i] ? acc + feat_ext : acc - feat_ext;
    assign hidden_bits[i] = ~next_acc[acc_bits-1];  // Sum >= 0

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        acc <= '0;
      end else if (start) begin
        acc <= '0;
      end else if (running) begin
        acc <= next_acc;
      end
    end
  end

  cnt_in_range: assert property (@(posedge clk) disable iff (rst)
    cnt < num_features);

endmodule

//--- bnn_output_layer.sv
`timescale 1ns/1ps

module bnn_output_layer (
  input logic clk,
  input logic rst,
  input logic [bnn_pkg::num_hidden-1:0] hidden_bits,
  input logic hidden_valid,
  bnn_ctrl_if.net ctrl
);
  import bnn_pkg::*;

  logic walking;
  logic last;
  logic done_q;
  logic [pos_bits-1:0] pos;
  logic [num_hidden-1:0] hid_q;
  logic [num_classes-1:0][score_bits-1:0] score_q;

  assign last = walking && (pos == pos_bits'(num_hidden - 1));
  assign ctrl.done = done_q;
  assign ctrl.scores = score_q;

  always_ff @(posedge clk) begin
    if (hidden_valid) begin
      hid_q <= hidden_bits;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos <= '0;
      walking <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= last;  // One cycle after the last position
      if (hidden_valid) begin
        pos <= '0;
        walking <= 1'b1;
      end else if (walking) begin
        if (last) begin
          pos <= '0;
          walking <= 1'b0;
        end else begin
          pos <= pos + 1'b1;
        end
      end
    end
  end

  // XNOR popcount, one hidden position per cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      score_q <= '0;
    end else if (ctrl.start || hidden_valid) begin
      score_q <= '0;
    end else if (walking) begin
      for (int c = 0; c < num_classes; c++) begin
        if (hid_q[pos] == output_weights[c][pos]) begin
          score_q[c] <= score_q[c] + 1'b1;
        end
      end
    end
  end

  // Hidden layer must not overrun an active walk
  no_valid_walking: assert property (@(posedge clk) disable iff (rst)
    hidden_valid |-> !walking);

endmodule

//--- bnn_pkg.sv
package bnn_pkg;

  // Network sizes
  localparam int num_features = 11;
  localparam int feature_bits = 4;
  localparam int num_hidden = 40;
  localparam int num_classes = 7;

  // Derived widths
  localparam int acc_bits = $clog2(num_features * (2 ** feature_bits - 1) + 1) + 1;
  localparam int score_bits = $clog2(num_hidden + 1);
  localparam int class_bits = $clog2(num_classes);
  localparam int feat_cnt_bits = $clog2(num_features);
  localparam int pos_bits = $clog2(num_hidden);

  // Wishbone sizes
  localparam int wb_addr_bits = 4;
  localparam int wb_data_bits = 32;
  localparam int feats_per_word = wb_data_bits / feature_bits;
  localparam int hi_feat_bits = (num_features - feats_per_word) * feature_bits;

  // Register map, word addresses
  localparam logic [wb_addr_bits-1:0] reg_ctrl = 4'd0;
  localparam logic [wb_addr_bits-1:0] reg_status = 4'd1;
  localparam logic [wb_addr_bits-1:0] reg_feat_lo = 4'd2;
  localparam logic [wb_addr_bits-1:0] reg_feat_hi = 4'd3;
  localparam logic [wb_addr_bits-1:0] reg_result = 4'd4;
  localparam logic [wb_addr_bits-1:0] reg_score_base = 4'd8;

  // Hidden layer signs, 1 adds the feature, row k belongs to feature k
  localparam logic [num_features-1:0][num_hidden-1:0] hidden_weights = {
    40'h5B_2566_3F86,  // Feature 10
    40'hE7_BDE8_30A6,
    40'hF1_0CB3_9575,
    40'hD1_238A_D539,
    40'h77_ACEF_8CDA,
    40'hD9_F20F_34D3,
    40'h42_D0FF_B893,
    40'h47_85CB_B151,
    40'hE3_4EC8_4272,
    40'h86_0012_D468,
    40'hAE_2713_2BF8   // Feature 0
  };

  // Output layer match pattern, row k belongs to class k
  localparam logic [num_classes-1:0][num_hidden-1:0] output_weights = {
    40'h6B_7AD9_5300,  // Class 6
    40'hE7_77F8_D1B0,
    40'hEB_72F0_D7B0,
    40'hCB_4233_0578,
    40'h3A_DCBE_3D7D,
    40'h8E_B72F_C663,
    40'h1E_3534_CC07   // Class 0
  };

endpackage

//--- bnn_wb_regs.sv
`timescale 1ns/1ps

module bnn_wb_regs (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic [bnn_pkg::wb_addr_bits-1:0] wb_adr,
  input logic [bnn_pkg::wb_data_bits-1:0] wb_dat_w,
  output logic [bnn_pkg::wb_data_bits-1:0] wb_dat_r,
  output logic wb_ack,
  bnn_ctrl_if.regs ctrl
);
  import bnn_pkg::*;

  logic req;
  logic wr_en;
  logic rd_en;
  logic ack_q;
  logic held;
  logic start_q;
  logic busy;
  logic done_flag;
  logic [num_features-1:0][feature_bits-1:0] feat_q;
  logic [wb_addr_bits-1:0] score_idx;
  logic [wb_data_bits-1:0] rd_data;
  logic [wb_data_bits-1:0] dat_q;

  assign req = wb_cyc && wb_stb;
  assign wr_en = req && !ack_q && !held && wb_we;  // One access per held request
  assign rd_en = req && !ack_q && !held && !wb_we;
  assign wb_ack = ack_q && wb_stb;
  assign wb_dat_r = dat_q;
  assign score_idx = wb_adr - reg_score_base;

  assign ctrl.start = start_q;
  assign ctrl.features = feat_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q <= 1'b0;
      held <= 1'b0;
      start_q <= 1'b0;
      busy <= 1'b0;
      done_flag <= 1'b0;
      feat_q <= '0;
    end else begin
      ack_q <= req && !ack_q && !held;
      held <= req && (ack_q || held);  // Set until stb drops
      start_q <= 1'b0;
      if (ctrl.done) begin
        busy <= 1'b0;
        done_flag <= 1'b1;
      end
      if (wr_en) begin
        case (wb_adr)
          reg_ctrl: begin
            if (wb_dat_w[0] && !busy) begin  // Ignored while a run is active
              start_q <= 1'b1;
              busy <= 1'b1;
              done_flag <= 1'b0;
            end
          end
          reg_feat_lo: feat_q[feats_per_word-1:0] <= wb_dat_w;
          reg_feat_hi: feat_q[num_features-1:feats_per_word] <= wb_dat_w[hi_feat_bits-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      reg_status: rd_data[1:0] = {done_flag, busy};
      reg_feat_lo: rd_data = feat_q[feats_per_word-1:0];
      reg_feat_hi: rd_data[hi_feat_bits-1:0] = feat_q[num_features-1:feats_per_word];
      reg_result: rd_data[class_bits-1:0] = ctrl.klass;
      default: begin
        if (wb_adr >= reg_score_base && wb_adr < reg_score_base + num_classes) begin
          rd_data[score_bits-1:0] = ctrl.scores[score_idx[class_bits-1:0]];
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      dat_q <= rd_data;
    end
  end

  // Ack only answers a request seen in the cycle before
  ack_after_req: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> $past(req));

  // A run cannot be launched on top of another
  no_start_busy: assert property (@(posedge clk) disable iff (rst)
    ctrl.start |-> !$past(busy));

endmodule

//--- files.f
bnn_pkg.sv
bnn_ctrl_if.sv
bnn_wb_regs.sv
bnn_hidden_layer.sv
bnn_output_layer.sv
bnn_argmax.sv
bnn_classifier.sv
tb_clkgen.sv
tb_bnn_classifier.sv

//--- tb_bnn_classifier.sv
`timescale 1ns/1ps

module tb_bnn_classifier #(
  parameter int seed = 89
);
  import bnn_pkg::*;

  localparam int table_rows = 10;
  localparam int num_random = 20;
  localparam int num_runs = table_rows + num_random + 3;
  localparam int run_cycles = 53 + 90;  // Network latency plus bus accesses and polling
  localparam int cycle_limit = 2 * num_runs * run_cycles + 500;
  localparam int feat_width = num_features * feature_bits;

  typedef logic [num_classes-1:0][score_bits-1:0] score_vec_t;

  logic clk;
  logic rst_por;
  logic rst_mid;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [wb_addr_bits-1:0] wb_adr;
  logic [wb_data_bits-1:0] wb_dat_w;
  logic [wb_data_bits-1:0] wb_dat_r;
  logic wb_ack;

  int cycles;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;
  logic [feat_width-1:0] table_feats [table_rows];
  string table_names [table_rows];
  score_vec_t table_scores [table_rows];
  logic [class_bits-1:0] table_class [table_rows];

  assign rst = rst_por | rst_mid;

  tb_clkgen clkgen0 (
    .clk(clk),
    .rst(rst_por)
  );

  bnn_classifier dut0 (
    .clk(clk),
    .rst(rst),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic wb_write(input logic [wb_addr_bits-1:0] adr, input logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b1;
    wb_adr <= adr;
    wb_dat_w <= data;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);  // Sampled mid-cycle
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic wb_read(input logic [wb_addr_bits-1:0] adr, output logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b0;
    wb_adr <= adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    data = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // Hidden sums and XNOR counts straight from the weight tables
  function automatic void compute_model(input logic [feat_width-1:0] feats,
                                        output score_vec_t scores,
                                        output logic [class_bits-1:0] klass);
    int sum;
    int feat;
    int cnt;
    int best;
    logic [num_hidden-1:0] hid;
    for (int i = 0; i < num_hidden; i++) begin
      sum = 0;
      for (int f = 0; f < num_features; f++) begin
        feat = int'(feats[f*feature_bits +: feature_bits]);
        sum = hidden_weights[f][i] ? sum + feat : sum - feat;
      end
      hid[i] = (sum >= 0);
    end
    for (int c = 0; c < num_classes; c++) begin
      cnt = 0;
      for (int i = 0; i < num_hidden; i++) begin
        if (hid[i] == output_weights[c][i]) cnt++;
      end
      scores[c] = score_bits'(cnt);
    end
    klass = '0;
    best = int'(scores[0]);
    for (int c = 1; c < num_classes; c++) begin
      if (int'(scores[c]) > best) begin  // Lowest index wins a tie
        best = int'(scores[c]);
        klass = class_bits'(c);
      end
    end
  endfunction

  task automatic load_features(input logic [feat_width-1:0] feats);
    wb_write(reg_feat_lo, feats[31:0]);
    wb_write(reg_feat_hi, 32'(feats[feat_width-1:32]));
  endtask

  task automatic start_run();
    wb_write(reg_ctrl, 32'h1);
  endtask

  task automatic wait_done(output logic [31:0] status);
    do begin
      wb_read(reg_status, status);
    end while (!status[1]);
  endtask

  task automatic check_outputs(input score_vec_t exp_scores,
                               input logic [class_bits-1:0] exp_class);
    logic [31:0] data;
    wb_read(reg_result, data);
    check("result", 32'(exp_class), data);
    for (int k = 0; k < num_classes; k++) begin
      wb_read(wb_addr_bits'(reg_score_base + k), data);
      check($sformatf("score[%0d]", k), 32'(exp_scores[k]), data);
    end
  endtask

  task automatic run_vector(input logic [feat_width-1:0] feats);
    score_vec_t exp_scores;
    logic [class_bits-1:0] exp_class;
    logic [31:0] status;
    compute_model(feats, exp_scores, exp_class);
    load_features(feats);
    start_run();
    wait_done(status);
    check_outputs(exp_scores, exp_class);
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] saved [16];
    logic [feat_width-1:0] feats_a;
    logic [feat_width-1:0] feats_b;
    score_vec_t exp_scores;
    logic [class_bits-1:0] exp_class;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    rst_mid = 1'b0;
    cycles = 0;
    errors = 0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(seed));

    table_feats[0] = 44'h000_0000_0000;
    table_names[0] = "all zero";
    table_feats[1] = 44'hfff_ffff_ffff;
    table_names[1] = "all fifteen";
    table_feats[2] = 44'hf0f_0f0f_0f0f;
    table_names[2] = "alternating even";
    table_feats[3] = 44'h0f0_f0f0_f0f0;
    table_names[3] = "alternating odd";
    table_feats[4] = 44'h000_0000_000f;
    table_names[4] = "single feature 0";
    table_feats[5] = 44'hf00_0000_0000;
    table_names[5] = "single feature 10";
    table_feats[6] = 44'h000_00f0_0000;
    table_names[6] = "single feature 5";
    table_feats[7] = 44'ha98_7654_3210;
    table_names[7] = "ramp";
    table_feats[8] = 44'h111_1111_1111;
    table_names[8] = "all one";
    table_feats[9] = 44'h3c8_1e05_9b2d;
    table_names[9] = "mixed";
    for (int r = 0; r < table_rows; r++) begin
      compute_model(table_feats[r], table_scores[r], table_class[r]);
    end

    while (rst !== 1'b0) @(posedge clk);
    repeat (2) @(posedge clk);

    wb_read(reg_status, data);
    check("status", 32'h0, data);
    wb_read(reg_feat_lo, data);
    check("feat_lo", 32'h0, data);
    wb_read(reg_feat_hi, data);
    check("feat_hi", 32'h0, data);
    check_outputs('0, '0);
    end_test("reset values");

    wb_write(reg_feat_lo, 32'hdead_beef);
    wb_read(reg_feat_lo, data);
    check("feat_lo", 32'hdead_beef, data);
    wb_write(reg_feat_hi, 32'hffff_ffff);
    wb_read(reg_feat_hi, data);
    check("feat_hi", 32'h0000_0fff, data);  // Only 3 features live here
    end_test("feature readback");

    for (int r = 0; r < table_rows; r++) begin
      load_features(table_feats[r]);
      start_run();
      wait_done(data);
      check_outputs(table_scores[r], table_class[r]);
      end_test(table_names[r]);
    end

    for (int n = 0; n < num_random; n++) begin
      feats_a = feat_width'({$urandom, $urandom});
      run_vector(feats_a);
    end
    end_test("random vectors");

    // Second start carries new features to expose a wrong restart
    feats_a = 44'h5e1_c0a7_39f4;
    feats_b = ~feats_a;
    compute_model(feats_a, exp_scores, exp_class);
    load_features(feats_a);
    start_run();
    load_features(feats_b);
    start_run();
    wb_read(reg_status, data);
    check("status while busy", 32'h1, data);
    wait_done(data);
    check("status after done", 32'h2, data);
    check_outputs(exp_scores, exp_class);
    end_test("start while busy");

    for (int a = 0; a < 16; a++) begin
      wb_read(wb_addr_bits'(a), saved[a]);
    end
    check("read addr 5", 32'h0, saved[5]);
    check("read addr 6", 32'h0, saved[6]);
    check("read addr 7", 32'h0, saved[7]);
    check("read addr 15", 32'h0, saved[15]);
    wb_write(4'd5, 32'hffff_ffff);
    wb_write(4'd6, 32'hffff_ffff);
    wb_write(4'd7, 32'hffff_ffff);
    wb_write(4'd15, 32'hffff_ffff);
    for (int a = 0; a < 16; a++) begin
      wb_read(wb_addr_bits'(a), data);
      check($sformatf("addr %0d after unmapped writes", a), saved[a], data);
    end
    end_test("unmapped addresses");

    load_features(44'h7c3_90e2_b5d1);
    start_run();
    repeat (20) @(posedge clk);  // Lands inside the output walk
    rst_mid <= 1'b1;
    repeat (2) @(posedge clk);
    rst_mid <= 1'b0;
    @(posedge clk);
    wb_read(reg_status, data);
    check("status after reset", 32'h0, data);
    check_outputs('0, '0);
    run_vector(44'h2b6_e19d_04c8);
    end_test("reset during run");

    $display("tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  localparam int half_period = 4;  // 8 ns clock
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
